// File: hw/trackerPkg.sv
// Shared widths, depths and types for the out-of-order read tracker
// Every RTL and testbench file refers to these by scoped name

package trackerPkg;

    // ======================================================================
    // Sizes
    // ======================================================================

    // Heap slots, also the limit on outstanding memory requests
    localparam int HEAP_ENTRIES = 16;

    // Free slots needed at the allocation pointer before the heap is not-full
    localparam int MIN_FREE_SLOTS = 1;

    // Request FIFO depth, also the host credit count after reset
    localparam int REQ_FIFO_DEPTH = 4;

    // Memory input slots, also the memory credit count after reset
    localparam int MEM_CREDITS = 2;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [15:0] addrT;
    typedef logic [7:0] userTagT;
    typedef logic [$clog2(HEAP_ENTRIES)-1:0] memTagT;
    typedef logic [31:0] dataT;

    // Heap entry, user tag in the upper bits and address in the lower bits
    typedef logic [$bits(userTagT)+$bits(addrT)-1:0] metaT;

    // Bit position where the user tag starts inside a metaT
    localparam int META_TAG_LSB = $bits(addrT);

    typedef logic [$clog2(REQ_FIFO_DEPTH)-1:0] fifoPtrT;

    // One spare bit above what MEM_CREDITS needs
    typedef logic [$clog2(MEM_CREDITS+1):0] memCreditT;

endpackage

// File: hw/tagHeap.sv
// Round-robin metadata heap for outstanding reads, indexed by memory tag
// Allocation writes the entry, reads return one cycle later, free releases the slot

`timescale 1ns/100ps

module tagHeap
(
    input  logic                clk,
    input  logic                resetb,

    // Allocation port
    input  logic                alloc,
    input  trackerPkg::metaT    allocMeta,
    output logic                notFull,
    output trackerPkg::memTagT  allocIdx,

    // Lookup port, data valid the cycle after readIdx
    input  trackerPkg::memTagT  readIdx,
    output trackerPkg::metaT    readMeta,

    // Release port
    input  logic                free,
    input  trackerPkg::memTagT  freeIdx
);

    // One bit per slot, set while the slot is free
    logic [trackerPkg::HEAP_ENTRIES-1:0] notBusy;

    // Next slot handed out
    trackerPkg::memTagT nextAlloc;

    // Low bits of notBusy appended above the top so the window never wraps
    logic [trackerPkg::MIN_FREE_SLOTS+trackerPkg::HEAP_ENTRIES-1:0] notBusyRepl;

    // Metadata storage
    trackerPkg::metaT heapMem [trackerPkg::HEAP_ENTRIES];

    assign allocIdx = nextAlloc;

    // ======================================================================
    // Allocation pointer and not-full window
    // ======================================================================

    assign notBusyRepl = {notBusy[trackerPkg::MIN_FREE_SLOTS-1:0], notBusy};

    // Every slot in the window starting at the pointer must be free
    assign notFull = &notBusyRepl[nextAlloc +: trackerPkg::MIN_FREE_SLOTS];

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            nextAlloc <= '0;
        end
        else if (alloc)
        begin
            // Step round robin, wrap after the last slot
            if (nextAlloc == trackerPkg::memTagT'(trackerPkg::HEAP_ENTRIES - 1))
            begin
                nextAlloc <= '0;
            end
            else
            begin
                nextAlloc <= nextAlloc + 1'b1;
            end
        end
    end

    // ======================================================================
    // Slot state
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            notBusy <= '1;
        end
        else
        begin
            // Claimed slot becomes busy
            if (alloc)
            begin
                notBusy[nextAlloc] <= 1'b0;
            end
            // Released slot; never the same slot as a claim in one cycle
            if (free)
            begin
                notBusy[freeIdx] <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Storage
    // ======================================================================

    always_ff @(posedge clk)
    begin
        // Registered lookup
        readMeta <= heapMem[readIdx];

        // Entry written when the slot is claimed
        if (alloc)
        begin
            heapMem[nextAlloc] <= allocMeta;
        end
    end

endmodule

// File: hw/reqDecode.sv
// Request side of the tracker: host request FIFO, credits, heap allocation
// Issues the FIFO head to memory when a heap slot and a memory credit are free

`timescale 1ns/100ps

module reqDecode
(
    input  logic                clk,
    input  logic                resetb,

    // Host request channel
    input  logic                hostReqValid,
    input  trackerPkg::addrT    hostReqAddr,
    input  trackerPkg::userTagT hostReqUserTag,
    output logic                hostReqCredit,

    // Memory request channel
    output logic                memReqValid,
    output trackerPkg::addrT    memReqAddr,
    output trackerPkg::memTagT  memReqTag,
    input  logic                memReqCredit,

    // Heap allocation port
    input  logic                heapNotFull,
    input  trackerPkg::memTagT  heapAllocIdx,
    output logic                heapAlloc,
    output trackerPkg::metaT    heapAllocMeta
);

    // FIFO storage, entries packed as {user tag, address}
    trackerPkg::metaT fifoMem [trackerPkg::REQ_FIFO_DEPTH];

    trackerPkg::fifoPtrT wrPtr;
    trackerPkg::fifoPtrT rdPtr;

    // Occupancy, one bit wider than a pointer to hold a full count
    logic [$bits(trackerPkg::fifoPtrT):0] fifoCount;

    // Memory credits still held
    trackerPkg::memCreditT memCredits;

    logic fifoEmpty;
    logic issue;

    // ======================================================================
    // Issue decision
    // ======================================================================

    assign fifoEmpty = (fifoCount == '0);

    // Head leaves when a slot is free and memory has room
    assign issue = !fifoEmpty && heapNotFull && (memCredits != '0);

    // Heap claims the slot on the same edge the memory request is loaded
    assign heapAlloc = issue;
    assign heapAllocMeta = fifoMem[rdPtr];

    // ======================================================================
    // Request FIFO
    // ======================================================================

    // Host never sends without a credit, so a write never finds the FIFO full
    always_ff @(posedge clk)
    begin
        if (hostReqValid)
        begin
            fifoMem[wrPtr] <= {hostReqUserTag, hostReqAddr};
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= '0;
        end
        else
        begin
            if (hostReqValid)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (issue)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            fifoCount <= fifoCount + hostReqValid - issue;
        end
    end

    // ======================================================================
    // Memory credits and request registers
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            memCredits <= trackerPkg::memCreditT'(trackerPkg::MEM_CREDITS);
            memReqValid <= 1'b0;
            hostReqCredit <= 1'b0;
        end
        else
        begin
            // Spend on issue, refill on return, both may land in one cycle
            memCredits <= memCredits - issue + memReqCredit;
            memReqValid <= issue;
            // FIFO slot freed, give the host its credit back
            hostReqCredit <= issue;
        end
    end

    // Payload, only meaningful while memReqValid is high
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            memReqAddr <= fifoMem[rdPtr][trackerPkg::META_TAG_LSB-1:0];
            memReqTag <= heapAllocIdx;
        end
    end

endmodule

// File: hw/rspResult.sv
// Response side of the tracker: metadata lookup by memory tag and host return
// Host response follows the memory response by exactly one cycle

`timescale 1ns/100ps

module rspResult
(
    input  logic                clk,
    input  logic                resetb,

    // Memory response channel
    input  logic                memRspValid,
    input  trackerPkg::memTagT  memRspTag,
    input  trackerPkg::dataT    memRspData,

    // Heap lookup and release
    output trackerPkg::memTagT  heapReadIdx,
    input  trackerPkg::metaT    heapReadMeta,
    output logic                heapFree,
    output trackerPkg::memTagT  heapFreeIdx,

    // Host response channel
    output logic                hostRspValid,
    output trackerPkg::addrT    hostRspAddr,
    output trackerPkg::userTagT hostRspUserTag,
    output trackerPkg::dataT    hostRspData
);

    // Response held while the heap lookup is in flight
    logic               rspValidQ;
    trackerPkg::memTagT rspTagQ;
    trackerPkg::dataT   rspDataQ;

    // ======================================================================
    // Lookup stage
    // ======================================================================

    // Tag goes straight to the heap, metadata comes back next cycle
    assign heapReadIdx = memRspTag;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rspValidQ <= 1'b0;
        end
        else
        begin
            rspValidQ <= memRspValid;
        end
    end

    // New response accepted every cycle, no stall
    always_ff @(posedge clk)
    begin
        rspTagQ <= memRspTag;
        rspDataQ <= memRspData;
    end

    // ======================================================================
    // Return stage
    // ======================================================================

    assign hostRspValid = rspValidQ;

    // Split the entry back into its fields
    assign hostRspAddr = heapReadMeta[trackerPkg::META_TAG_LSB-1:0];
    assign hostRspUserTag = heapReadMeta[trackerPkg::META_TAG_LSB +: $bits(trackerPkg::userTagT)];

    assign hostRspData = rspDataQ;

    // Slot released as the response leaves
    assign heapFree = rspValidQ;
    assign heapFreeIdx = rspTagQ;

endmodule

// File: hw/readTracker.sv
// Top level of the out-of-order read tracker
// Decode stage issues requests, heap holds metadata, result stage answers the host

`timescale 1ns/100ps

module readTracker
(
    input  logic                clk,
    input  logic                resetb,

    // Host request channel
    input  logic                hostReqValid,
    input  trackerPkg::addrT    hostReqAddr,
    input  trackerPkg::userTagT hostReqUserTag,
    output logic                hostReqCredit,

    // Memory request channel
    output logic                memReqValid,
    output trackerPkg::addrT    memReqAddr,
    output trackerPkg::memTagT  memReqTag,
    input  logic                memReqCredit,

    // Memory response channel
    input  logic                memRspValid,
    input  trackerPkg::memTagT  memRspTag,
    input  trackerPkg::dataT    memRspData,

    // Host response channel
    output logic                hostRspValid,
    output trackerPkg::addrT    hostRspAddr,
    output trackerPkg::userTagT hostRspUserTag,
    output trackerPkg::dataT    hostRspData
);

    // Allocation side of the heap
    logic               heapNotFull;
    trackerPkg::memTagT heapAllocIdx;
    logic               heapAlloc;
    trackerPkg::metaT   heapAllocMeta;

    // Lookup and release side of the heap
    trackerPkg::memTagT heapReadIdx;
    trackerPkg::metaT   heapReadMeta;
    logic               heapFree;
    trackerPkg::memTagT heapFreeIdx;

    // ======================================================================
    // Request path
    // ======================================================================

    reqDecode u_reqDecode
    (
        .clk            (clk),
        .resetb         (resetb),
        .hostReqValid   (hostReqValid),
        .hostReqAddr    (hostReqAddr),
        .hostReqUserTag (hostReqUserTag),
        .hostReqCredit  (hostReqCredit),
        .memReqValid    (memReqValid),
        .memReqAddr     (memReqAddr),
        .memReqTag      (memReqTag),
        .memReqCredit   (memReqCredit),
        .heapNotFull    (heapNotFull),
        .heapAllocIdx   (heapAllocIdx),
        .heapAlloc      (heapAlloc),
        .heapAllocMeta  (heapAllocMeta)
    );

    // Metadata store, slot index doubles as the memory tag
    tagHeap u_tagHeap
    (
        .clk       (clk),
        .resetb    (resetb),
        .alloc     (heapAlloc),
        .allocMeta (heapAllocMeta),
        .notFull   (heapNotFull),
        .allocIdx  (heapAllocIdx),
        .readIdx   (heapReadIdx),
        .readMeta  (heapReadMeta),
        .free      (heapFree),
        .freeIdx   (heapFreeIdx)
    );

    // ======================================================================
    // Response path
    // ======================================================================

    rspResult u_rspResult
    (
        .clk            (clk),
        .resetb         (resetb),
        .memRspValid    (memRspValid),
        .memRspTag      (memRspTag),
        .memRspData     (memRspData),
        .heapReadIdx    (heapReadIdx),
        .heapReadMeta   (heapReadMeta),
        .heapFree       (heapFree),
        .heapFreeIdx    (heapFreeIdx),
        .hostRspValid   (hostRspValid),
        .hostRspAddr    (hostRspAddr),
        .hostRspUserTag (hostRspUserTag),
        .hostRspData    (hostRspData)
    );

endmodule

// File: test/memModel.sv
// Out-of-order memory model for the read tracker testbench
// Takes requests under credits, holds them in a pool, answers them in random order

`timescale 1ns/100ps

module memModel
(
    input  logic                clk,
    input  logic                resetb,

    // Freezes all answers while high
    input  logic                hold,

    // Request channel from the tracker
    input  logic                memReqValid,
    input  trackerPkg::addrT    memReqAddr,
    input  trackerPkg::memTagT  memReqTag,
    output logic                memReqCredit,

    // Response channel back to the tracker
    output logic                memRspValid,
    output trackerPkg::memTagT  memRspTag,
    output trackerPkg::dataT    memRspData
);

    // Pending entry, tag above address
    localparam int ENTRY_W = $bits(trackerPkg::memTagT) + $bits(trackerPkg::addrT);

    typedef logic [ENTRY_W-1:0] entryT;

    entryT inSlots [$];
    entryT pool [$];
    entryT entry;
    trackerPkg::addrT rspAddr;
    integer seed;
    int pick;
    logic active;
    logic frozen;

    initial
    begin
        seed = 65775;
        memReqCredit = 1'b0;
        memRspValid = 1'b0;
        memRspTag = '0;
        memRspData = '0;
        forever
        begin
            // Inputs are stable mid-cycle
            @(negedge clk);
            active = resetb;
            frozen = hold;
            if (!active)
            begin
                inSlots.delete();
                pool.delete();
            end
            else if (memReqValid)
            begin
                inSlots.push_back({memReqTag, memReqAddr});
            end

            @(posedge clk);
            #2;
            memReqCredit = 1'b0;
            memRspValid = 1'b0;
            if (active)
            begin
                // Input slot drains into the pool, which hands a credit back
                if (inSlots.size() != 0 && ($random(seed) & 3) != 0)
                begin
                    pool.push_back(inSlots.pop_front());
                    memReqCredit = 1'b1;
                end
                // Answer any pending entry, not the oldest
                if (!frozen && pool.size() != 0 && ($random(seed) & 1) == 1)
                begin
                    pick = $unsigned($random(seed)) % pool.size();
                    entry = pool[pick];
                    pool.delete(pick);
                    rspAddr = entry[0 +: $bits(trackerPkg::addrT)];
                    memRspValid = 1'b1;
                    memRspTag = entry[$bits(trackerPkg::addrT) +: $bits(trackerPkg::memTagT)];
                    // Address in the high half, scrambled address in the low half
                    memRspData = {rspAddr, rspAddr ^ 16'hA5C3};
                end
            end
        end
    end

endmodule

// File: test/trackerTb.sv
// Testbench for the out-of-order read tracker
// Fills the heap with memory on hold, then runs random traffic against a scoreboard

`timescale 1ns/100ps

module trackerTb;

    // ======================================================================
    // Test sizes and time limit
    // ======================================================================

    localparam int RESET_CYCLES = 10;
    // Enough to fill every heap slot and the request FIFO behind it
    localparam int HOLD_REQS = trackerPkg::HEAP_ENTRIES + trackerPkg::REQ_FIFO_DEPTH;
    localparam int RANDOM_REQS = 300;
    localparam int TOTAL_REQS = HOLD_REQS + RANDOM_REQS;
    // Cycles with memory frozen and the heap full
    localparam int HOLD_CYCLES = 40;
    // Generous per-request budget on top of the fixed phases
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + HOLD_CYCLES + TOTAL_REQS * 20 + 100;

    logic               clk;
    logic               resetb;
    logic               hold;
    logic               hostReqValid;
    trackerPkg::addrT   hostReqAddr;
    trackerPkg::userTagT hostReqUserTag;
    logic               hostReqCredit;
    logic               memReqValid;
    trackerPkg::addrT   memReqAddr;
    trackerPkg::memTagT memReqTag;
    logic               memReqCredit;
    logic               memRspValid;
    trackerPkg::memTagT memRspTag;
    trackerPkg::dataT   memRspData;
    logic               hostRspValid;
    trackerPkg::addrT   hostRspAddr;
    trackerPkg::userTagT hostRspUserTag;
    trackerPkg::dataT   hostRspData;

    // Requests in send order with the issued ones below issueIdx
    trackerPkg::addrT    sentAddr [$];
    trackerPkg::userTagT sentUser [$];
    int issueIdx = 0;

    // Per-slot model of what memory holds
    logic [trackerPkg::HEAP_ENTRIES-1:0] slotBusy = '0;
    trackerPkg::addrT    slotAddr [trackerPkg::HEAP_ENTRIES];
    trackerPkg::userTagT slotUser [trackerPkg::HEAP_ENTRIES];
    trackerPkg::memTagT  nextTag = '0;
    trackerPkg::memTagT  rspTag = '0;
    logic rspPending = 1'b0;

    int outstanding = 0;
    int issued = 0;
    int answered = 0;
    int memUnaccepted = 0;
    int creditsBack = 0;
    int creditsSpent = 0;
    int issuedBefore;
    integer seed;

    readTracker u_readTracker
    (
        .clk            (clk),
        .resetb         (resetb),
        .hostReqValid   (hostReqValid),
        .hostReqAddr    (hostReqAddr),
        .hostReqUserTag (hostReqUserTag),
        .hostReqCredit  (hostReqCredit),
        .memReqValid    (memReqValid),
        .memReqAddr     (memReqAddr),
        .memReqTag      (memReqTag),
        .memReqCredit   (memReqCredit),
        .memRspValid    (memRspValid),
        .memRspTag      (memRspTag),
        .memRspData     (memRspData),
        .hostRspValid   (hostRspValid),
        .hostRspAddr    (hostRspAddr),
        .hostRspUserTag (hostRspUserTag),
        .hostRspData    (hostRspData)
    );

    memModel u_memModel
    (
        .clk          (clk),
        .resetb       (resetb),
        .hold         (hold),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memReqTag    (memReqTag),
        .memReqCredit (memReqCredit),
        .memRspValid  (memRspValid),
        .memRspTag    (memRspTag),
        .memRspData   (memRspData)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // Failure reporting and compare tasks
    // ======================================================================

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkAddr(input string name, input trackerPkg::addrT exp,
                             input trackerPkg::addrT act);
        if (exp !== act)
            stopRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic checkUserTag(input string name, input trackerPkg::userTagT exp,
                                input trackerPkg::userTagT act);
        if (exp !== act)
            stopRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic checkData(input string name, input trackerPkg::dataT exp,
                             input trackerPkg::dataT act);
        if (exp !== act)
            stopRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic checkMemTag(input string name, input trackerPkg::memTagT exp,
                               input trackerPkg::memTagT act);
        if (exp !== act)
            stopRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    // Host sends at most one request per cycle while it holds a credit
    task automatic sendRequests(input int count);
        int sent;
        sent = 0;
        while (sent < count)
        begin
            @(posedge clk);
            #2;
            if (trackerPkg::REQ_FIFO_DEPTH + creditsBack - creditsSpent > 0
                && ($random(seed) & 3) != 0)
            begin
                hostReqValid = 1'b1;
                hostReqAddr = trackerPkg::addrT'($random(seed));
                hostReqUserTag = trackerPkg::userTagT'($random(seed));
                sentAddr.push_back(hostReqAddr);
                sentUser.push_back(hostReqUserTag);
                creditsSpent++;
                sent++;
            end
            else
            begin
                hostReqValid = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        hostReqValid = 1'b0;
    endtask

    // ======================================================================
    // Scoreboard monitor sampling mid-cycle
    // ======================================================================

    always @(negedge clk)
    begin
        if (resetb)
        begin
            // Host answer is due one cycle after the memory answer
            if (rspPending)
            begin
                if (!hostRspValid)
                    stopRun("Host response missing one cycle after memory response");
                checkUserTag("host response user tag", slotUser[rspTag], hostRspUserTag);
                checkAddr("host response address", slotAddr[rspTag], hostRspAddr);
                checkData("host response data",
                          {slotAddr[rspTag], slotAddr[rspTag] ^ 16'hA5C3}, hostRspData);
                slotBusy[rspTag] = 1'b0;
                outstanding--;
                answered++;
            end
            else if (hostRspValid)
            begin
                stopRun("Host response without a memory response before it");
            end
            rspPending = 1'b0;
            if (memRspValid)
            begin
                if (!slotBusy[memRspTag])
                    stopRun("Memory answered a tag that is not outstanding");
                rspPending = 1'b1;
                rspTag = memRspTag;
            end
            // Issue order follows send order and tags go round robin
            if (memReqValid)
            begin
                if (issueIdx >= sentAddr.size())
                    stopRun("Memory request with no host request behind it");
                checkMemTag("memory request tag", nextTag, memReqTag);
                checkAddr("memory request address", sentAddr[issueIdx], memReqAddr);
                if (slotBusy[memReqTag])
                    stopRun("Memory tag issued while still outstanding");
                slotBusy[memReqTag] = 1'b1;
                slotAddr[memReqTag] = sentAddr[issueIdx];
                slotUser[memReqTag] = sentUser[issueIdx];
                issueIdx++;
                nextTag = nextTag + 1'b1;
                outstanding++;
                issued++;
                memUnaccepted++;
                if (outstanding > trackerPkg::HEAP_ENTRIES)
                    stopRun("More memory requests outstanding than heap slots");
            end
            if (memReqCredit)
                memUnaccepted--;
            if (memUnaccepted > trackerPkg::MEM_CREDITS || memUnaccepted < 0)
                stopRun("Memory input slots overrun by the tracker");
            if (hostReqCredit)
                creditsBack++;
            if (creditsBack > creditsSpent)
                stopRun("Tracker returned more host credits than it was given");
        end
    end

    // Watchdog
    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: requests were not all answered in time");
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        seed = 65775;
        resetb = 1'b0;
        hold = 1'b1;
        hostReqValid = 1'b0;
        hostReqAddr = '0;
        hostReqUserTag = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        resetb = 1'b1;

        // Heap fills and the host stalls while memory is frozen
        sendRequests(HOLD_REQS);
        while (outstanding < trackerPkg::HEAP_ENTRIES)
            @(posedge clk);
        issuedBefore = issued;
        repeat (HOLD_CYCLES) @(posedge clk);
        if (issued != issuedBefore)
            stopRun("Tracker issued a request with every heap slot busy");
        if (creditsBack != creditsSpent - trackerPkg::REQ_FIFO_DEPTH)
            stopRun("Host credits returned while the request FIFO was full");
        #2;
        hold = 1'b0;

        // Random traffic with memory answering out of order
        sendRequests(RANDOM_REQS);
        while (answered < TOTAL_REQS)
            @(posedge clk);
        repeat (5) @(posedge clk);

        if (outstanding != 0 || issueIdx != sentAddr.size() || slotBusy != '0)
        begin
            stopRun("Scoreboard not empty at the end of the run");
        end
        else if (creditsBack != creditsSpent || memUnaccepted != 0)
        begin
            stopRun("Credits not all returned at the end of the run");
        end
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: vlog.f
hw/trackerPkg.sv
hw/tagHeap.sv
hw/reqDecode.sv
hw/rspResult.sv
hw/readTracker.sv
test/memModel.sv
test/trackerTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the read tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module trackerTb -o trackerSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

simOut=$(./obj_dir/trackerSim 2>&1)
simStatus=$?
echo "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
